// File: common/level_mon_pkg.sv
`default_nettype none

package level_mon_pkg;

  // Bus side
  typedef logic [15:0] wb_addr_t;
  typedef logic [15:0] wb_data_t;

  // ADC side
  typedef logic [11:0] adc_value_t;           // Result or threshold
  typedef logic [4:0]  adc_chan_t;
  typedef logic [6:0]  thr_addr_t;            // {hard, chan, high}
  typedef logic [31:0] chan_mask_t;           // One bit per channel

  localparam int         THR_DEPTH = 128;     // Threshold RAM words, also bus RAM window
  localparam logic [1:0] LAST_PASS = 2'b11;   // Hard high is the final compare

  typedef struct packed {
    adc_chan_t  chan;
    adc_value_t value;
  } adc_sample_t;

  typedef struct packed {
    logic       captured;                     // Held until source read
    adc_chan_t  chan;
    adc_value_t value;
  } viol_rec_t;

  typedef struct packed {
    logic       we;
    thr_addr_t  addr;
    adc_value_t data;
  } thr_wr_t;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    SEND
  } chk_state_e;

  // Register space sits directly above the RAM window
  localparam wb_addr_t REG_SOFT_VALID = 16'd128;
  localparam wb_addr_t REG_HARD_VALID = 16'd129;
  localparam wb_addr_t REG_SOFT_SRC   = 16'd130;  // Read clears soft record
  localparam wb_addr_t REG_SOFT_VAL   = 16'd131;
  localparam wb_addr_t REG_HARD_SRC   = 16'd132;  // Read clears hard record
  localparam wb_addr_t REG_HARD_VAL   = 16'd133;
  localparam wb_addr_t REG_INRANGE_LO = 16'd134;
  localparam wb_addr_t REG_INRANGE_HI = 16'd135;

endpackage

`default_nettype wire

// File: source/threshold_ram.sv
`timescale 1ns/1ps
`default_nettype none

module threshold_ram (
  input  logic                      wb_clk_i,
  input  level_mon_pkg::thr_wr_t    thr_wr_i,
  input  level_mon_pkg::thr_addr_t  raddr_i,
  output level_mon_pkg::adc_value_t rdata_o
);

  import level_mon_pkg::*;

  adc_value_t mem [THR_DEPTH];                // Soft thresholds low half, hard high half

  always_ff @(posedge wb_clk_i) begin
    if (thr_wr_i.we) begin
      mem[thr_wr_i.addr] <= thr_wr_i.data;
    end
  end

  // Read data one cycle after the address
  always_ff @(posedge wb_clk_i) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

// File: level_checker/lc_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lc_bus_regs (
  input  logic                      wb_clk_i,
  input  logic                      wb_rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  level_mon_pkg::wb_addr_t   wb_adr_i,
  input  level_mon_pkg::wb_data_t   wb_dat_i,
  output level_mon_pkg::wb_data_t   wb_dat_o,
  output logic                      wb_ack_o,
  input  logic                      soft_reset_i,
  input  level_mon_pkg::thr_addr_t  chk_raddr_i,
  input  level_mon_pkg::adc_value_t ram_rdata_i,
  input  level_mon_pkg::viol_rec_t  soft_rec_i,
  input  level_mon_pkg::viol_rec_t  hard_rec_i,
  input  level_mon_pkg::chan_mask_t in_range_i,
  output level_mon_pkg::thr_wr_t    thr_wr_o,
  output level_mon_pkg::thr_addr_t  ram_raddr_o,
  output logic                      bus_rd_busy_o,
  output logic                      soft_en_o,
  output logic                      hard_en_o,
  output logic                      clear_soft_o,
  output logic                      clear_hard_o
);

  import level_mon_pkg::*;

  logic      wb_trans;
  logic      wb_ram_sel;
  logic      bus_rd_start;
  logic      rd_wait_q;
  wb_addr_t  rd_adr_q;
  thr_addr_t bus_thr_addr;

  assign wb_trans     = wb_cyc_i & wb_stb_i & ~wb_ack_o;     // Accept once per request
  assign wb_ram_sel   = wb_adr_i < wb_addr_t'(THR_DEPTH);
  assign bus_rd_start = wb_trans & wb_ram_sel & ~wb_we_i;
  assign bus_thr_addr = wb_adr_i[$bits(thr_addr_t)-1:0];

  assign thr_wr_o = '{
    we:   wb_trans & wb_ram_sel & wb_we_i,
    addr: bus_thr_addr,
    data: wb_dat_i[$bits(adc_value_t)-1:0]
  };

  // The bus only needs the address in its accepting cycle; the checker gets
  // the port back for the ack cycle, so its data is fresh right after busy
  assign ram_raddr_o   = bus_rd_start ? bus_thr_addr : chk_raddr_i;
  assign bus_rd_busy_o = bus_rd_start | rd_wait_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o     <= 1'b0;
      rd_wait_q    <= 1'b0;
      soft_en_o    <= 1'b0;
      hard_en_o    <= 1'b0;
      clear_soft_o <= 1'b0;
      clear_hard_o <= 1'b0;
    end else begin
      wb_ack_o     <= wb_trans;
      rd_wait_q    <= bus_rd_start;                          // RAM data comes back with ack
      clear_soft_o <= wb_trans & ~wb_we_i & (wb_adr_i == REG_SOFT_SRC);
      clear_hard_o <= wb_trans & ~wb_we_i & (wb_adr_i == REG_HARD_SRC);

      if (wb_trans && wb_we_i) begin
        if (wb_adr_i == REG_SOFT_VALID) begin
          soft_en_o <= wb_dat_i[0];
        end
        if (wb_adr_i == REG_HARD_VALID) begin
          hard_en_o <= wb_dat_i[0];
        end
      end

      if (soft_reset_i) begin
        soft_en_o <= 1'b0;                                   // Soft reset wins over a write
      end
    end
  end

  // Read-back selector
  always_ff @(posedge wb_clk_i) begin
    if (wb_trans) begin
      rd_adr_q <= wb_adr_i;
    end
  end

  always_comb begin
    wb_dat_o = '0;
    if (rd_adr_q < wb_addr_t'(THR_DEPTH)) begin
      wb_dat_o = wb_data_t'(ram_rdata_i);                    // Upper bits read as zero
    end else begin
      case (rd_adr_q)
        REG_SOFT_VALID: wb_dat_o = wb_data_t'(soft_en_o);
        REG_HARD_VALID: wb_dat_o = wb_data_t'(hard_en_o);
        REG_SOFT_SRC:   wb_dat_o = wb_data_t'({soft_rec_i.captured, soft_rec_i.chan});
        REG_SOFT_VAL:   wb_dat_o = wb_data_t'(soft_rec_i.value);
        REG_HARD_SRC:   wb_dat_o = wb_data_t'({hard_rec_i.captured, hard_rec_i.chan});
        REG_HARD_VAL:   wb_dat_o = wb_data_t'(hard_rec_i.value);
        REG_INRANGE_LO: wb_dat_o = in_range_i[15:0];
        REG_INRANGE_HI: wb_dat_o = in_range_i[31:16];
        default:        wb_dat_o = '0;                       // Unmapped reads as zero
      endcase
    end
  end

endmodule

`default_nettype wire

// File: level_checker/lc_threshold_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lc_threshold_fsm (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       adc_strb_i,
  input  level_mon_pkg::adc_sample_t adc_sample_i,
  input  level_mon_pkg::adc_value_t  ram_rdata_i,
  input  logic                       bus_rd_busy_i,
  input  logic                       soft_en_i,
  input  logic                       hard_en_i,
  input  logic                       clear_soft_i,
  input  logic                       clear_hard_i,
  output level_mon_pkg::thr_addr_t   chk_raddr_o,
  output logic                       soft_viol_o,
  output logic                       hard_viol_o,
  output logic                       sample_done_o,
  output level_mon_pkg::viol_rec_t   soft_rec_o,
  output level_mon_pkg::viol_rec_t   hard_rec_o,
  output level_mon_pkg::chan_mask_t  in_range_o
);

  import level_mon_pkg::*;

  chk_state_e  state_q;
  adc_sample_t sample_q;
  logic [1:0]  pass_q;                        // {hard, high}
  logic        wait_q;
  logic        soft_fail_q;
  logic        hard_fail_q;
  logic        compare_en;
  logic        thr_broken;

  assign chk_raddr_o = {pass_q[1], sample_q.chan, pass_q[0]};
  assign compare_en  = ~wait_q & ~bus_rd_busy_i;     // RAM data belongs to this pass

  // High pass fails below the result, low pass fails above it
  assign thr_broken = pass_q[0] ? (ram_rdata_i < sample_q.value)
                                : (ram_rdata_i > sample_q.value);

  // Sample is held so the sequencer can move on
  always_ff @(posedge wb_clk_i) begin
    if (state_q == IDLE && adc_strb_i) begin
      sample_q <= adc_sample_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q       <= IDLE;
      pass_q        <= '0;
      wait_q        <= 1'b0;
      soft_fail_q   <= 1'b0;
      hard_fail_q   <= 1'b0;
      soft_viol_o   <= 1'b0;
      hard_viol_o   <= 1'b0;
      sample_done_o <= 1'b0;
      soft_rec_o    <= '0;
      hard_rec_o    <= '0;
      in_range_o    <= '0;
    end else begin
      soft_viol_o   <= 1'b0;
      hard_viol_o   <= 1'b0;
      sample_done_o <= 1'b0;

      if (clear_soft_i) begin
        soft_rec_o.captured <= 1'b0;
      end
      if (clear_hard_i) begin
        hard_rec_o.captured <= 1'b0;
      end

      case (state_q)
        IDLE: begin
          if (adc_strb_i) begin
            state_q     <= CHECK;
            pass_q      <= '0;
            wait_q      <= 1'b1;                     // Address goes out first
            soft_fail_q <= 1'b0;
            hard_fail_q <= 1'b0;
          end
        end

        CHECK: begin
          if (wait_q) begin
            wait_q <= 1'b0;
          end else if (compare_en) begin
            if (!pass_q[1] && soft_en_i) begin
              soft_fail_q <= soft_fail_q | thr_broken;
            end
            if (pass_q[1] && hard_en_i) begin
              hard_fail_q <= hard_fail_q | thr_broken;
            end
            if (pass_q == LAST_PASS) begin
              state_q <= SEND;
            end else begin
              pass_q <= pass_q + 2'd1;
              wait_q <= 1'b1;
            end
          end
        end

        SEND: begin
          sample_done_o <= 1'b1;                     // Sequencer advances on this
          soft_viol_o   <= soft_fail_q;
          hard_viol_o   <= hard_fail_q;
          if (hard_en_i) begin
            in_range_o[sample_q.chan] <= ~hard_fail_q;
          end
          // First violation only, but a same-cycle clear frees the slot
          if (soft_fail_q && (!soft_rec_o.captured || clear_soft_i)) begin
            soft_rec_o <= '{captured: 1'b1, chan: sample_q.chan, value: sample_q.value};
          end
          if (hard_fail_q && (!hard_rec_o.captured || clear_hard_i)) begin
            hard_rec_o <= '{captured: 1'b1, chan: sample_q.chan, value: sample_q.value};
          end
          state_q <= IDLE;
        end

        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/level_mon_top.sv
`timescale 1ns/1ps
`default_nettype none

module level_mon_top (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  level_mon_pkg::wb_addr_t    wb_adr_i,
  input  level_mon_pkg::wb_data_t    wb_dat_i,
  output level_mon_pkg::wb_data_t    wb_dat_o,
  output logic                       wb_ack_o,
  input  logic                       adc_strb_i,
  input  level_mon_pkg::adc_sample_t adc_sample_i,
  input  logic                       soft_reset_i,
  output logic                       soft_viol_o,
  output logic                       hard_viol_o,
  output logic                       sample_done_o,
  output level_mon_pkg::chan_mask_t  in_range_o
);

  import level_mon_pkg::*;

  thr_wr_t    thr_wr;
  thr_addr_t  ram_raddr;
  thr_addr_t  chk_raddr;
  adc_value_t ram_rdata;
  logic       bus_rd_busy;
  logic       soft_en;
  logic       hard_en;
  logic       clear_soft;
  logic       clear_hard;
  viol_rec_t  soft_rec;
  viol_rec_t  hard_rec;

  threshold_ram threshold_ram_inst (
    .wb_clk_i (wb_clk_i),
    .thr_wr_i (thr_wr),
    .raddr_i  (ram_raddr),
    .rdata_o  (ram_rdata)
  );

  lc_bus_regs lc_bus_regs_inst (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .soft_reset_i  (soft_reset_i),
    .chk_raddr_i   (chk_raddr),
    .ram_rdata_i   (ram_rdata),
    .soft_rec_i    (soft_rec),
    .hard_rec_i    (hard_rec),
    .in_range_i    (in_range_o),
    .thr_wr_o      (thr_wr),
    .ram_raddr_o   (ram_raddr),
    .bus_rd_busy_o (bus_rd_busy),
    .soft_en_o     (soft_en),
    .hard_en_o     (hard_en),
    .clear_soft_o  (clear_soft),
    .clear_hard_o  (clear_hard)
  );

  lc_threshold_fsm lc_threshold_fsm_inst (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .adc_strb_i    (adc_strb_i),
    .adc_sample_i  (adc_sample_i),
    .ram_rdata_i   (ram_rdata),
    .bus_rd_busy_i (bus_rd_busy),
    .soft_en_i     (soft_en),
    .hard_en_i     (hard_en),
    .clear_soft_i  (clear_soft),
    .clear_hard_i  (clear_hard),
    .chk_raddr_o   (chk_raddr),
    .soft_viol_o   (soft_viol_o),
    .hard_viol_o   (hard_viol_o),
    .sample_done_o (sample_done_o),
    .soft_rec_o    (soft_rec),
    .hard_rec_o    (hard_rec),
    .in_range_o    (in_range_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam time HALF_PERIOD = 50ns;         // 100 ns clock

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 rst_o = 1'b0;                          // Released just after the third edge
  end

endmodule

`default_nettype wire

// File: tb/level_mon_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module level_mon_assertions (
  input logic                      wb_clk_i,
  input logic                      wb_rst_i,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic                      wb_ack_i,
  input logic                      adc_strb_i,
  input level_mon_pkg::chk_state_e chk_state_i,
  input logic                      bus_rd_busy_i,
  input logic                      soft_viol_i,
  input logic                      hard_viol_i,
  input logic                      sample_done_i
);

  import level_mon_pkg::*;

  int   fail_count = 0;                       // Read by the testbench at the end
  logic req_accepted;
  logic strb_accepted;

  assign req_accepted  = wb_cyc_i & wb_stb_i & ~wb_ack_i;
  assign strb_accepted = adc_strb_i & (chk_state_i == IDLE);

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |=> !wb_ack_i)
    else begin
      $error("Acknowledge stayed high for two cycles");
      fail_count++;
    end

  ack_after_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    req_accepted |=> wb_ack_i)
    else begin
      $error("Accepted request was not acknowledged in the next cycle");
      fail_count++;
    end

  ack_has_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |-> $past(req_accepted))
    else begin
      $error("Acknowledge without an accepted request one cycle earlier");
      fail_count++;
    end

  viol_with_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (soft_viol_i || hard_viol_i) |-> sample_done_i)
    else begin
      $error("Violation pulse without sample done");
      fail_count++;
    end

  // Ten cycles from strobe to done when no bus read stalls the compares
  done_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    strb_accepted ##1 (!bus_rd_busy_i)[*9] |=> sample_done_i)
    else begin
      $error("Sample done did not follow the strobe after ten cycles");
      fail_count++;
    end

  done_not_early: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    strb_accepted |=> (!sample_done_i)[*9])
    else begin
      $error("Sample done came before ten cycles had passed");
      fail_count++;
    end

endmodule

bind level_mon_top level_mon_assertions level_mon_assertions_inst (
  .wb_clk_i      (wb_clk_i),
  .wb_rst_i      (wb_rst_i),
  .wb_cyc_i      (wb_cyc_i),
  .wb_stb_i      (wb_stb_i),
  .wb_ack_i      (wb_ack_o),
  .adc_strb_i    (adc_strb_i),
  .chk_state_i   (lc_threshold_fsm_inst.state_q),
  .bus_rd_busy_i (bus_rd_busy),
  .soft_viol_i   (soft_viol_o),
  .hard_viol_i   (hard_viol_o),
  .sample_done_i (sample_done_o)
);

`default_nettype wire

// File: tb/level_mon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module level_mon_tb;

  import level_mon_pkg::*;

  localparam int MAX_CYCLES = 4000;

  logic        wb_clk;
  logic        wb_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_w;
  wb_data_t    wb_dat_r;
  logic        wb_ack;
  logic        adc_strb;
  adc_sample_t adc_sample;
  logic        soft_reset;
  logic        soft_viol;
  logic        hard_viol;
  logic        sample_done;
  chan_mask_t  in_range;

  adc_value_t  thr_model [THR_DEPTH];         // Thresholds as written
  viol_rec_t   soft_rec_m;
  viol_rec_t   hard_rec_m;
  chan_mask_t  in_range_m;
  logic        soft_en_m;
  logic        hard_en_m;
  int          error_count = 0;
  int          cycle_count = 0;

  tb_clock_gen clock_gen_inst (
    .clk_o (wb_clk),
    .rst_o (wb_rst)
  );

  level_mon_top level_mon_top_inst (
    .wb_clk_i      (wb_clk),
    .wb_rst_i      (wb_rst),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack),
    .adc_strb_i    (adc_strb),
    .adc_sample_i  (adc_sample),
    .soft_reset_i  (soft_reset),
    .soft_viol_o   (soft_viol),
    .hard_viol_o   (hard_viol),
    .sample_done_o (sample_done),
    .in_range_o    (in_range)
  );

  // Low limit broken above the result, high limit below it
  function automatic logic window_broken(input adc_value_t lo, input adc_value_t hi,
                                         input adc_value_t value);
    return (lo > value) || (hi < value);
  endfunction

  function automatic logic [31:0] src_word(input viol_rec_t rec);
    return {26'd0, rec.captured, rec.chan};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        error_count++;
      end
  endtask

  task automatic bus_cycle(input wb_addr_t addr, input logic we, input wb_data_t wdata,
                           output wb_data_t rdata);
    @(posedge wb_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = wdata;
    @(negedge wb_clk);
    while (!wb_ack) @(negedge wb_clk);
    rdata = wb_dat_r;                          // Valid with ack
    @(posedge wb_clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_threshold(input thr_addr_t addr, input wb_data_t data);
    wb_data_t unused;
    bus_cycle(wb_addr_t'(addr), 1'b1, data, unused);
    thr_model[addr] = data[11:0];
  endtask

  task automatic read_check(input string name, input wb_addr_t addr,
                            input logic [31:0] expected);
    wb_data_t rdata;
    bus_cycle(addr, 1'b0, '0, rdata);
    check_value(name, expected, {16'd0, rdata});
    if (addr == REG_SOFT_SRC) begin
      soft_rec_m.captured = 1'b0;
    end
    if (addr == REG_HARD_SRC) begin
      hard_rec_m.captured = 1'b0;
    end
  endtask

  task automatic set_enable(input wb_addr_t addr, input logic en);
    wb_data_t unused;
    bus_cycle(addr, 1'b1, wb_data_t'(en), unused);
    if (addr == REG_SOFT_VALID) begin
      soft_en_m = en;
    end else begin
      hard_en_m = en;
    end
  endtask

  // Windows narrow with the channel number so every word differs
  task automatic fill_thresholds();
    thr_addr_t  addr;
    adc_value_t offset;
    adc_value_t value;
    for (int a = 0; a < THR_DEPTH; a++) begin
      addr   = thr_addr_t'(a);
      offset = adc_value_t'(addr[5:1]);
      case ({addr[6], addr[0]})
        2'b00:   value = 12'h400 + offset;
        2'b01:   value = 12'hC00 - offset;
        2'b10:   value = 12'h200 + offset;
        default: value = 12'hE00 - offset;
      endcase
      write_threshold(addr, wb_data_t'(value));
    end
  endtask

  task automatic run_sample(input string name, input adc_chan_t chan, input adc_value_t value);
    logic exp_soft;
    logic exp_hard;
    exp_soft = soft_en_m && window_broken(thr_model[{1'b0, chan, 1'b0}],
                                          thr_model[{1'b0, chan, 1'b1}], value);
    exp_hard = hard_en_m && window_broken(thr_model[{1'b1, chan, 1'b0}],
                                          thr_model[{1'b1, chan, 1'b1}], value);
    @(posedge wb_clk);
    #1;
    adc_strb   = 1'b1;
    adc_sample = '{chan: chan, value: value};
    @(posedge wb_clk);
    #1;
    adc_strb = 1'b0;
    @(negedge wb_clk);
    while (!sample_done) @(negedge wb_clk);
    check_value({name, " soft_viol"}, {31'd0, exp_soft}, {31'd0, soft_viol});
    check_value({name, " hard_viol"}, {31'd0, exp_hard}, {31'd0, hard_viol});
    if (exp_soft && !soft_rec_m.captured) begin
      soft_rec_m = '{captured: 1'b1, chan: chan, value: value};
    end
    if (exp_hard && !hard_rec_m.captured) begin
      hard_rec_m = '{captured: 1'b1, chan: chan, value: value};
    end
    if (hard_en_m) begin
      in_range_m[chan] = ~exp_hard;
    end
    check_value({name, " in_range"}, in_range_m, in_range);
  endtask

  always @(posedge wb_clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d check failures", error_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    adc_chan_t  chan;
    adc_value_t value;
    thr_addr_t  raddr;
    thr_addr_t  waddr [12];
    int         delay;
    int         assert_fails;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    adc_strb   = 1'b0;
    adc_sample = '0;
    soft_reset = 1'b0;
    soft_rec_m = '0;
    hard_rec_m = '0;
    in_range_m = '0;
    soft_en_m  = 1'b0;
    hard_en_m  = 1'b0;
    void'($urandom(32'h970e5dc3));
    wait (!wb_rst);

    // Random RAM words, upper data bits must read back as zero
    foreach (waddr[i]) begin
      waddr[i] = thr_addr_t'($urandom_range(127, 0));
      write_threshold(waddr[i], wb_data_t'($urandom));
    end
    foreach (waddr[i]) begin
      read_check("ram_readback", wb_addr_t'(waddr[i]), {20'd0, thr_model[waddr[i]]});
    end

    fill_thresholds();
    set_enable(REG_SOFT_VALID, 1'b1);
    set_enable(REG_HARD_VALID, 1'b1);
    run_sample("in_range ch5", 5'd5, 12'h800);
    run_sample("in_range ch20", 5'd20, 12'h800);
    read_check("in_range lo", REG_INRANGE_LO, {16'd0, in_range_m[15:0]});
    read_check("in_range hi", REG_INRANGE_HI, {16'd0, in_range_m[31:16]});

    run_sample("soft_low", 5'd3, 12'h300);
    run_sample("soft_high", 5'd7, 12'hD00);    // Must not replace the first record
    read_check("soft_val", REG_SOFT_VAL, {20'd0, soft_rec_m.value});
    read_check("soft_src", REG_SOFT_SRC, src_word(soft_rec_m));
    run_sample("soft_high again", 5'd7, 12'hD00);
    read_check("soft_src next", REG_SOFT_SRC, src_word(soft_rec_m));
    read_check("soft_val next", REG_SOFT_VAL, {20'd0, soft_rec_m.value});

    run_sample("hard_low", 5'd5, 12'h100);
    read_check("hard in_range", REG_INRANGE_LO, {16'd0, in_range_m[15:0]});
    read_check("hard_src", REG_HARD_SRC, src_word(hard_rec_m));
    read_check("hard_val", REG_HARD_VAL, {20'd0, hard_rec_m.value});

    set_enable(REG_HARD_VALID, 1'b0);
    run_sample("hard_disabled", 5'd20, 12'hF00);
    read_check("hard_disabled map", REG_INRANGE_HI, {16'd0, in_range_m[31:16]});
    set_enable(REG_SOFT_VALID, 1'b0);
    run_sample("soft_disabled", 5'd3, 12'h000);
    set_enable(REG_SOFT_VALID, 1'b1);
    set_enable(REG_HARD_VALID, 1'b1);
    @(posedge wb_clk);
    #1;
    soft_reset = 1'b1;
    @(posedge wb_clk);
    #1;
    soft_reset = 1'b0;
    soft_en_m  = 1'b0;
    read_check("soft_reset soft", REG_SOFT_VALID, {31'd0, soft_en_m});
    read_check("soft_reset hard", REG_HARD_VALID, {31'd0, hard_en_m});
    set_enable(REG_SOFT_VALID, 1'b1);

    // Bus reads land at random points of a running check
    for (int i = 0; i < 20; i++) begin
      chan  = adc_chan_t'($urandom_range(31, 0));
      value = adc_value_t'($urandom_range(4095, 0));
      raddr = thr_addr_t'($urandom_range(127, 0));
      delay = $urandom_range(8, 1);
      fork
        run_sample("bus_during_check", chan, value);
        begin
          repeat (delay) @(posedge wb_clk);
          read_check("bus_during_check ram", wb_addr_t'(raddr), {20'd0, thr_model[raddr]});
        end
      join
    end
    read_check("final soft_src", REG_SOFT_SRC, src_word(soft_rec_m));
    read_check("final hard_src", REG_HARD_SRC, src_word(hard_rec_m));
    read_check("final in_range lo", REG_INRANGE_LO, {16'd0, in_range_m[15:0]});
    read_check("final in_range hi", REG_INRANGE_HI, {16'd0, in_range_m[31:16]});

    repeat (12) @(posedge wb_clk);
    assert_fails = level_mon_top_inst.level_mon_assertions_inst.fail_count;
    $display("Errors: %0d check failures, %0d assertion failures", error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/level_mon_pkg.sv
source/threshold_ram.sv
level_checker/lc_bus_regs.sv
level_checker/lc_threshold_fsm.sv
source/level_mon_top.sv
tb/tb_clock_gen.sv
tb/level_mon_assertions.sv
tb/level_mon_tb.sv
